// ==== verification/decode_tests.txt ====
# name instr rs1 rs2 rd imm alu_op illegal (all hex)
# alu_op: 0 pass 1 add 2 sub 3 and 4 or 5 xor 6 sll 7 srl 8 sra 9 sltu a-f eq ne lt ge ltu geu
add     003100B3 02 03 01 00000000 1 0
sub     403100B3 02 03 01 00000000 2 0
sll     003110B3 02 03 01 00000000 6 0
xor     003140B3 02 03 01 00000000 5 0
srl     003150B3 02 03 01 00000000 7 0
sra     403150B3 02 03 01 00000000 8 0
or      003160B3 02 03 01 00000000 4 0
and     003170B3 02 03 01 00000000 3 0
addi_n  FFF30293 06 00 05 FFFFFFFF 1 0
addi_p  06430293 06 00 05 00000064 1 0
andi    0F037293 06 00 05 000000F0 3 0
ori_n   80036293 06 00 05 FFFFF800 4 0
xori    7FF34293 06 00 05 000007FF 5 0
slli    00531293 06 00 05 00000005 6 0
sltiu   00133293 06 00 05 00000001 9 0
srli    00335293 06 00 05 00000003 7 0
srai    40335293 06 00 05 00000403 8 0
addiw   FFE3029B 06 00 05 FFFFFFFE 1 0
slliw   0023129B 06 00 05 00000002 6 0
srliw   0043529B 06 00 05 00000004 7 0
sraiw   4043529B 06 00 05 00000404 8 0
jalr    008100E7 02 00 01 00000008 1 0
ld      FF843383 08 00 07 FFFFFFF8 1 0
lw      00442383 08 00 07 00000004 1 0
lbu     00044383 08 00 07 00000000 1 0
sb      FE310FA3 02 03 00 FFFFFFFF 1 0
sh      02311023 02 03 00 00000020 1 0
sw      00312623 02 03 00 0000000C 1 0
sd      FE313823 02 03 00 FFFFFFF0 1 0
beq     00310863 02 03 00 00000010 a 0
bne     FE311EE3 02 03 00 FFFFFFFC b 0
blt     003140E3 02 03 00 00000800 c 0
bge     02315063 02 03 00 00000020 d 0
bltu    00316263 02 03 00 00000004 e 0
bgeu    80317063 02 03 00 FFFFF000 f 0
lui     12345537 00 00 0A 12345000 0 0
lui_n   FFFFF537 00 00 0A FFFFF000 0 0
auipc   00001517 00 00 0A 00001000 1 0
jal_p   008000EF 00 00 01 00000008 1 0
jal_n   FFFFF0EF 00 00 01 FFFFFFFE 1 0
bad_op  003100FF 00 00 00 00000000 0 1
bad_f7  023100B3 00 00 00 00000000 0 1
slt     003120B3 00 00 00 00000000 0 1
sll_alt 403110B3 00 00 00 00000000 0 1
br_f3   00312863 00 00 00 00000000 0 1
lh      00441383 00 00 00 00000000 0 1
slti    00132293 00 00 00 00000000 0 1
jalr_f3 008110E7 00 00 00 00000000 0 1
slli_hi 40531293 00 00 00 00000000 0 1

// ==== list.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/id_ex_reg.sv
rtl/rv_id_stage.sv
verification/tb_clock_gen.sv
verification/rv_id_stage_assertions.sv
verification/rv_id_stage_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module rv_id_stage_tb -o sim
	@out=$$(./obj_dir/sim 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== verification/rv_id_stage_tb.sv ====
module rv_id_stage_tb;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    rv_isa_pkg::instr_word_u instr;
    logic                    id_valid;
    rv_ctrl_pkg::alu_op_e    id_alu_op;
    logic                    id_illegal;
    logic [4:0]              id_rs1;
    logic [4:0]              id_rs2;
    logic [4:0]              id_rd;
    logic signed [31:0]      id_imm;

    string       names[$];     // Test vectors from the data file
    logic [31:0] words[$];
    logic [31:0] exp_rs1[$];
    logic [31:0] exp_rs2[$];
    logic [31:0] exp_rd[$];
    logic [31:0] exp_imm[$];
    logic [31:0] exp_alu[$];
    logic [31:0] exp_ill[$];
    int          pending[$];   // Strobed but not yet seen at the output
    int          checked;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv_id_stage i_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .id_valid    (id_valid),
        .id_alu_op   (id_alu_op),
        .id_illegal  (id_illegal),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_rd       (id_rd),
        .id_imm      (id_imm)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else
            stop_with_error($sformatf("Mismatch %s %s: expected %h, actual %h",
                                      test, field, expected, actual));
    endtask

    task automatic load_tests();
        int          fd;
        int          count;
        string       line;
        string       name;
        logic [31:0] f[7];
        fd = $fopen("verification/decode_tests.txt", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open verification/decode_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
            count = $sscanf(line, "%s %h %h %h %h %h %h %h", name,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (count != 8) begin
                stop_with_error($sformatf("Malformed test line: %s", line));
            end
            names.push_back(name);
            words.push_back(f[0]);
            exp_rs1.push_back(f[1]);
            exp_rs2.push_back(f[2]);
            exp_rd.push_back(f[3]);
            exp_imm.push_back(f[4]);
            exp_alu.push_back(f[5]);
            exp_ill.push_back(f[6]);
        end
        $fclose(fd);
    endtask

    task automatic drive_tests();
        int gap;
        for (int k = 0; k < words.size(); k++) begin
            gap = $urandom % 4;  // 0 gives back-to-back strobes
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr       <= words[k];
            instr_valid <= 1'b1;
            pending.push_back(k);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic check_outputs();
        int waited;
        int idx;
        for (int k = 0; k < words.size(); k++) begin
            waited = 0;
            @(negedge clk);  // Outputs settled mid-cycle
            while (!id_valid) begin
                waited++;
                if (waited > 10) begin
                    stop_with_error("Timeout: id_valid did not rise within 10 cycles");
                end
                @(negedge clk);
            end
            assert (pending.size() > 0) else
                stop_with_error("id_valid high with no instruction pending");
            idx = pending.pop_front();
            check_field(names[idx], "rs1", exp_rs1[idx], 32'(id_rs1));
            check_field(names[idx], "rs2", exp_rs2[idx], 32'(id_rs2));
            check_field(names[idx], "rd", exp_rd[idx], 32'(id_rd));
            check_field(names[idx], "imm", exp_imm[idx], id_imm);
            check_field(names[idx], "alu_op", exp_alu[idx], 32'(id_alu_op));
            check_field(names[idx], "illegal", exp_ill[idx], 32'(id_illegal));
            checked++;
        end
    endtask

    initial begin
        int cycles;
        instr_valid = 1'b0;
        instr       = '0;
        checked     = 0;
        cycles      = 0;
        void'($urandom(32'h7c5d_48af));  // Fixed seed for gap pattern
        load_tests();
        @(negedge clk);  // Reset level settled
        while (reset) begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) stop_with_error("Reset was never released");
        end
        assert (!id_valid && !id_illegal) else
            stop_with_error("id_valid or id_illegal high after reset");
        check_field("reset", "rs1", 32'h0, 32'(id_rs1));
        check_field("reset", "rs2", 32'h0, 32'(id_rs2));
        check_field("reset", "rd", 32'h0, 32'(id_rd));
        check_field("reset", "imm", 32'h0, id_imm);
        check_field("reset", "alu_op", 32'h0, 32'(id_alu_op));
        fork
            drive_tests();
            check_outputs();
        join
        @(negedge clk);
        assert (!id_valid) else stop_with_error("Extra id_valid after last test");
        if (checked == words.size() && checked > 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_error("Not every test vector was checked");
        end
    end

endmodule

// ==== verification/rv_id_stage_assertions.sv ====
module rv_id_stage_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 instr_valid,
    input logic                 id_valid,
    input rv_ctrl_pkg::alu_op_e id_alu_op,
    input logic                 id_illegal,
    input logic [4:0]           id_rs1,
    input logic [4:0]           id_rs2,
    input logic [4:0]           id_rd
);

    import rv_ctrl_pkg::*;

    // Nothing valid right after reset
    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !id_valid)
        else $error("id_valid high in the cycle after reset");

    // One cycle of latency on the strobe
    a_valid_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (id_valid == $past(instr_valid)))
        else $error("id_valid does not follow instr_valid by one cycle");

    // Illegal words carry no operation
    a_illegal_is_empty: assert property (@(posedge clk) disable iff (reset)
        id_illegal |-> (id_alu_op == ALU_PASS && id_rs1 == '0 && id_rs2 == '0 && id_rd == '0))
        else $error("Illegal instruction with nonzero fields or ALU op");

endmodule

bind rv_id_stage rv_id_stage_assertions i_assertions (.*);

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // Period 100
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);  // Two cycles in reset
        reset <= 1'b0;
    end

endmodule

// ==== rtl/rv_id_stage.sv ====
`include "rv_decoder_macros.svh"

module rv_id_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  rv_isa_pkg::instr_word_u  instr,
    output logic                     id_valid,
    output rv_ctrl_pkg::alu_op_e     id_alu_op,
    output logic                     id_illegal,
    output logic [`REG_ADDR_W-1:0]   id_rs1,
    output logic [`REG_ADDR_W-1:0]   id_rs2,
    output logic [`REG_ADDR_W-1:0]   id_rd,
    output logic signed [`XLEN-1:0]  id_imm
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    instr_fmt_e              fmt;      // Decoder to immediate generator
    alu_op_e                 alu_op;
    logic                    illegal;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`REG_ADDR_W-1:0]  rd;
    logic signed [`XLEN-1:0] imm;

    instr_decoder i_decoder (
        .instr   (instr),
        .fmt     (fmt),
        .alu_op  (alu_op),
        .illegal (illegal),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .fmt   (fmt),              // Zero for illegal
        .imm   (imm)
    );

    id_ex_reg i_id_ex_reg (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .alu_op      (alu_op),
        .illegal     (illegal),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .id_valid    (id_valid),
        .id_alu_op   (id_alu_op),
        .id_illegal  (id_illegal),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_rd       (id_rd),
        .id_imm      (id_imm)
    );

endmodule

// ==== rtl/id_ex_reg.sv ====
`include "rv_decoder_macros.svh"

module id_ex_reg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  rv_ctrl_pkg::alu_op_e     alu_op,
    input  logic                     illegal,
    input  logic [`REG_ADDR_W-1:0]   rs1,
    input  logic [`REG_ADDR_W-1:0]   rs2,
    input  logic [`REG_ADDR_W-1:0]   rd,
    input  logic signed [`XLEN-1:0]  imm,
    output logic                     id_valid,
    output rv_ctrl_pkg::alu_op_e     id_alu_op,
    output logic                     id_illegal,
    output logic [`REG_ADDR_W-1:0]   id_rs1,
    output logic [`REG_ADDR_W-1:0]   id_rs2,
    output logic [`REG_ADDR_W-1:0]   id_rd,
    output logic signed [`XLEN-1:0]  id_imm
);

    import rv_ctrl_pkg::*;

    // Valid follows the strobe, payload loads on strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid   <= 1'b0;
            id_alu_op  <= ALU_PASS;      // Code zero
            id_illegal <= 1'b0;
            id_rs1     <= '0;
            id_rs2     <= '0;
            id_rd      <= '0;
            id_imm     <= '0;
        end else begin
            id_valid <= instr_valid;     // One cycle per strobe
            if (instr_valid) begin
                id_alu_op  <= alu_op;
                id_illegal <= illegal;
                id_rs1     <= rs1;
                id_rs2     <= rs2;
                id_rd      <= rd;
                id_imm     <= imm;
            end
        end
    end

endmodule

// ==== rtl/imm_gen.sv ====
`include "rv_decoder_macros.svh"

module imm_gen (
    input  rv_isa_pkg::instr_word_u  instr,
    input  rv_isa_pkg::instr_fmt_e   fmt,
    output logic signed [`XLEN-1:0]  imm
);

    import rv_isa_pkg::*;

    logic sign;  // Instruction bit 31 in every format

    assign sign = instr[`INSTR_W-1];

    always_comb begin
        case (fmt)
            FMT_I: begin
                imm = {{(`XLEN-12){sign}}, instr.i.imm};
            end
            FMT_S: begin
                imm = {{(`XLEN-12){sign}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            FMT_B: begin
                imm = {{(`XLEN-13){sign}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};                           // Halfword aligned
            end
            FMT_U: begin
                imm = {instr.u.imm_31_12, 12'h000};     // Upper 20 bits, low zeroed
            end
            FMT_J: begin
                imm = {{(`XLEN-21){sign}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};                           // Halfword aligned
            end
            default: begin
                imm = '0;                               // R format and illegal
            end
        endcase
    end

endmodule

// ==== rtl/instr_decoder.sv ====
`include "rv_decoder_macros.svh"

module instr_decoder (
    input  rv_isa_pkg::instr_word_u  instr,
    output rv_isa_pkg::instr_fmt_e   fmt,
    output rv_ctrl_pkg::alu_op_e     alu_op,
    output logic                     illegal,
    output logic [`REG_ADDR_W-1:0]   rs1,
    output logic [`REG_ADDR_W-1:0]   rs2,
    output logic [`REG_ADDR_W-1:0]   rd
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;  // funct7 all zero
    logic       f7_alt;   // funct7 bit 30 set
    logic       alt_ok;   // funct3 allows the alternate funct7

    assign opcode  = instr.r.opcode;
    assign funct3  = instr.r.funct3;
    assign funct7  = instr.r.funct7;
    assign f7_base = (funct7 == FUNCT7_BASE);
    assign f7_alt  = (funct7 == FUNCT7_ALT);
    assign alt_ok  = (funct3 == F3_ADD) || (funct3 == F3_SR);  // Only ADD/SUB and SRL/SRA

    // Format and ALU op classification
    always_comb begin
        fmt     = FMT_R;
        alu_op  = ALU_PASS;
        illegal = 1'b0;
        case (opcode)
            OP: begin
                fmt = FMT_R;
                case (funct3)
                    F3_ADD:  alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: illegal = 1'b1;  // SLT, SLTU not supported
                endcase
                if (!(f7_base || (f7_alt && alt_ok))) begin
                    illegal = 1'b1;  // Bad funct7 for this funct3
                end
            end
            OP_IMM: begin
                fmt = FMT_I;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;   // ADDI
                    F3_AND:  alu_op = ALU_AND;   // ANDI
                    F3_OR:   alu_op = ALU_OR;    // ORI
                    F3_XOR:  alu_op = ALU_XOR;   // XORI
                    F3_SLTU: alu_op = ALU_SLTU;  // SLTIU
                    F3_SLL: begin
                        alu_op  = ALU_SLL;       // SLLI
                        illegal = !f7_base;
                    end
                    F3_SR: begin
                        alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                        illegal = !(f7_base || f7_alt);
                    end
                    default: illegal = 1'b1;     // SLTI
                endcase
            end
            OP_IMM_32: begin
                fmt = FMT_I;  // Word forms share the 64-bit codes
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;   // ADDIW
                    F3_SLL: begin
                        alu_op  = ALU_SLL;       // SLLIW
                        illegal = !f7_base;
                    end
                    F3_SR: begin
                        alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                        illegal = !(f7_base || f7_alt);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            JALR: begin
                fmt     = FMT_I;
                alu_op  = ALU_ADD;               // Target rs1 + imm
                illegal = (funct3 != F3_JALR);
            end
            LOAD: begin
                fmt    = FMT_I;
                alu_op = ALU_ADD;                // Effective address
                case (funct3)
                    F3_LW, F3_LD, F3_LBU: illegal = 1'b0;
                    default:              illegal = 1'b1;
                endcase
            end
            STORE: begin
                fmt    = FMT_S;
                alu_op = ALU_ADD;
                case (funct3)
                    F3_SB, F3_SH, F3_SW, F3_SD: illegal = 1'b0;
                    default:                    illegal = 1'b1;
                endcase
            end
            BRANCH: begin
                fmt = FMT_B;
                case (funct3)
                    F3_BEQ:  alu_op = ALU_EQ;
                    F3_BNE:  alu_op = ALU_NE;
                    F3_BLT:  alu_op = ALU_LT;
                    F3_BGE:  alu_op = ALU_GE;
                    F3_BLTU: alu_op = ALU_LTU;
                    F3_BGEU: alu_op = ALU_GEU;
                    default: illegal = 1'b1;     // 010 and 011 unused
                endcase
            end
            LUI: begin
                fmt    = FMT_U;
                alu_op = ALU_PASS;               // rd gets the immediate
            end
            AUIPC: begin
                fmt    = FMT_U;
                alu_op = ALU_ADD;                // PC + imm
            end
            JAL: begin
                fmt    = FMT_J;
                alu_op = ALU_ADD;                // Return address PC + 4
            end
            default: illegal = 1'b1;             // Unknown opcode
        endcase

        if (illegal) begin
            fmt    = FMT_R;                      // Forces a zero immediate
            alu_op = ALU_PASS;
        end
    end

    // Register address masking per format
    always_comb begin
        rs1 = instr.r.rs1;
        rs2 = instr.r.rs2;
        rd  = instr.r.rd;
        if (illegal) begin
            rs1 = '0;                            // No register write either
            rs2 = '0;
            rd  = '0;
        end else begin
            case (fmt)
                FMT_I: rs2 = '0;
                FMT_S, FMT_B: rd = '0;           // No destination
                FMT_U, FMT_J: begin
                    rs1 = '0;
                    rs2 = '0;
                end
                default: rd = instr.r.rd;        // R uses all three
            endcase
        end
    end

endmodule

// ==== rtl/rv_ctrl_pkg.sv ====
`include "rv_decoder_macros.svh"

package rv_ctrl_pkg;

    // One code per operation across all opcode groups
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_PASS = 4'h0,  // Operand B straight through, LUI and illegal
        ALU_ADD  = 4'h1,  // Also address calc and link
        ALU_SUB  = 4'h2,
        ALU_AND  = 4'h3,
        ALU_OR   = 4'h4,
        ALU_XOR  = 4'h5,
        ALU_SLL  = 4'h6,
        ALU_SRL  = 4'h7,
        ALU_SRA  = 4'h8,
        ALU_SLTU = 4'h9,  // SLTIU

        // Branch compares
        ALU_EQ   = 4'ha,
        ALU_NE   = 4'hb,
        ALU_LT   = 4'hc,
        ALU_GE   = 4'hd,
        ALU_LTU  = 4'he,
        ALU_GEU  = 4'hf
    } alu_op_e;

endpackage

// ==== rtl/rv_isa_pkg.sv ====
`include "rv_decoder_macros.svh"

package rv_isa_pkg;

    // Major opcodes, bits 6..0
    typedef enum logic [6:0] {
        OP        = 7'b0110011,  // Register-register ALU
        OP_IMM    = 7'b0010011,  // Register-immediate ALU
        OP_IMM_32 = 7'b0011011,  // Word forms ADDIW etc
        JALR      = 7'b1100111,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111
    } opcode_e;

    // Selects the immediate layout downstream
    typedef enum logic [2:0] {
        FMT_R = 3'd0,  // No immediate
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5
    } instr_fmt_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;  // ADD, SRL and friends
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // SUB, SRA

    // ALU group funct3
    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    // Load widths
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;

    // Store widths
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]            imm;     // imm[11:0]
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]             imm_hi;  // imm[11:5]
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;  // imm[4:0]
        logic [6:0]             opcode;
    } s_view_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;   // Sits in bit 7
        logic [6:0]             opcode;
    } b_view_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_view_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_view_t;

    // Same 32 bits seen through each format
    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        b_view_t b;
        u_view_t u;
        j_view_t j;
    } instr_word_u;

endpackage

// ==== rtl/rv_decoder_macros.svh ====
`ifndef RV_DECODER_MACROS_SVH
`define RV_DECODER_MACROS_SVH

// Instruction word width
`define INSTR_W 32

// Immediate and datapath width
`define XLEN 32

`define REG_ADDR_W 5  // x0..x31

`define ALU_OP_W 4    // Sixteen ALU codes

`endif
